// File: include/trace_monitor_config.svh
/*
 * trace monitor configuration macros
 * widths, buffer depth and the WFI stop settings
 */
`ifndef TRACE_MONITOR_CONFIG_SVH
`define TRACE_MONITOR_CONFIG_SVH

// pc and instruction widths of the traced core
`define TRACE_XLEN 32
`define TRACE_INSTR_WIDTH 32

// cycle delta width, saturating counter
`define TRACE_DELTA_WIDTH 32

// packed output word: instr, pc, delta
`define TRACE_DATA_WIDTH (`TRACE_XLEN + `TRACE_INSTR_WIDTH + `TRACE_DELTA_WIDTH)

// record FIFO entries, power of two, 2 or more
`define TRACE_BUFFER_DEPTH 8

// wfi encoding and the hold time before the final record
`define TRACE_WFI_INSTR 32'h10500073
`define TRACE_WFI_THRESHOLD 16

`endif

// File: project.f
+incdir+include
source/trace_monitor_pkg.sv
source/trace_record_if.sv
source/trace_control_regs.sv
source/trace_capture.sv
source/trace_buffer.sv
source/trace_stream_out.sv
source/trace_monitor_top.sv
verification/trace_monitor_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the trace monitor simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module trace_monitor_tb

out=$(./obj_dir/Vtrace_monitor_tb)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
else
    exit 1
fi

// File: source/trace_buffer.sv
/*
 * circular FIFO of trace records with a full flag
 */
`timescale 1ns/1ps
`default_nettype none

`include "trace_monitor_config.svh"

module trace_buffer (
    input  wire logic      clk,
    input  wire logic      rst_n,
    trace_record_if.sink   in,
    trace_record_if.source out,
    output logic           full
);
    import trace_monitor_pkg::*;

    localparam int DEPTH = `TRACE_BUFFER_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    trace_record_t    mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // one wider than the pointers so that DEPTH fits
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign full  = (count == (PTR_W + 1)'(DEPTH));
    assign push  = in.valid && !full;
    assign pop   = out.valid && out.ready;

    assign in.ready   = !full;
    assign out.valid  = (count != '0);
    assign out.record = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in.record;
        end
    end

    // pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/trace_capture.sv
/*
 * trace record producer
 * pc/instr history, run end detection, range and trigger gating,
 * wfi stop and cycle delta counter
 */
`timescale 1ns/1ps
`default_nettype none

`include "trace_monitor_config.svh"

module trace_capture (
    input  wire logic                             clk,
    input  wire logic                             rst_n,
    input  wire logic [`TRACE_XLEN-1:0]           pc,
    input  wire logic [`TRACE_INSTR_WIDTH-1:0]    instr,
    input  wire logic                             en,
    input  wire trace_monitor_pkg::trace_config_t cfg,
    trace_record_if.source                        out
);
    import trace_monitor_pkg::*;

    localparam int WFI_THRESH = `TRACE_WFI_THRESHOLD;
    localparam int WFI_CNT_W  = $clog2(WFI_THRESH + 1);

    logic [`TRACE_XLEN-1:0]        s0_pc;
    logic [`TRACE_XLEN-1:0]        s1_pc;
    logic [`TRACE_INSTR_WIDTH-1:0] s0_instr;
    logic [`TRACE_INSTR_WIDTH-1:0] s1_instr;
    logic [WFI_CNT_W-1:0]          wfi_cnt;
    logic [`TRACE_DELTA_WIDTH-1:0] delta_cnt;
    logic                          start_reached;
    logic                          end_reached;
    logic                          s1_is_wfi;
    logic                          run_end;
    logic                          wfi_fire;
    logic                          in_range;
    logic                          in_window;
    logic                          keep;
    logic                          load;
    logic                          out_valid;
    trace_record_t                 out_rec;
    trace_record_t                 rec_next;

    // two stage history, stage 1 is the run being judged
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s0_pc    <= '0;
            s0_instr <= '0;
            s1_pc    <= '0;
            s1_instr <= '0;
        end else begin
            s0_pc    <= pc;
            s0_instr <= instr;
            s1_pc    <= s0_pc;
            s1_instr <= s0_instr;
        end
    end

    assign s1_is_wfi = (s1_instr == `TRACE_WFI_INSTR);
    // a run ends when a different pc follows it
    assign run_end   = (s1_pc != s0_pc) && (s1_pc != '0) && !s1_is_wfi;
    // fires on the step that brings the hold count to the threshold
    assign wfi_fire  = s1_is_wfi && en && (wfi_cnt == WFI_CNT_W'(WFI_THRESH - 1));

    assign in_range  = (!cfg.range_lower_en || (s1_pc >= cfg.range_lower)) &&
                       (!cfg.range_upper_en || (s1_pc <= cfg.range_upper));
    assign in_window = (start_reached || !cfg.trigger_start_en) &&
                       (!end_reached || !cfg.trigger_end_en);

    assign keep = (run_end || wfi_fire) && en && in_range && in_window;
    // an occupied output register drops the new record
    assign load = keep && (!out_valid || out.ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wfi_cnt <= '0;
        end else if (!s1_is_wfi || cfg.wfi_stop_clear) begin
            wfi_cnt <= '0;
        end else if (en && (wfi_cnt < WFI_CNT_W'(WFI_THRESH))) begin
            wfi_cnt <= wfi_cnt + 1'b1;
        end
    end

    // trigger window, judged on the pc entering the history
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_reached <= 1'b0;
            end_reached   <= 1'b0;
        end else begin
            if (cfg.trigger_start_en && (s0_pc == cfg.trigger_start)) begin
                start_reached <= 1'b1;
                end_reached   <= 1'b0;
            end
            if (cfg.trigger_end_en && (s0_pc == cfg.trigger_end)) begin
                end_reached   <= 1'b1;
                start_reached <= 1'b0;
            end
        end
    end

    // cycles since the last record, restarts at one on each load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            delta_cnt <= '0;
        end else if (load) begin
            delta_cnt <= `TRACE_DELTA_WIDTH'(1);
        end else if (delta_cnt != '1) begin
            delta_cnt <= delta_cnt + 1'b1;
        end
    end

    always_comb begin
        rec_next.pc    = s1_pc;
        rec_next.instr = s1_instr;
        rec_next.delta = delta_cnt;
        rec_next.last  = wfi_fire;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out.ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_rec <= rec_next;
        end
    end

    assign out.valid  = out_valid;
    assign out.record = out_rec;

endmodule

`default_nettype wire

// File: source/trace_control_regs.sv
/*
 * control register file for the trace monitor
 * level-sensitive writes through address and data
 */
`timescale 1ns/1ps
`default_nettype none

`include "trace_monitor_config.svh"

module trace_control_regs (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire trace_monitor_pkg::ctrl_addr_e  ctrl_addr,
    input  wire logic [`TRACE_XLEN-1:0]         ctrl_wdata,
    input  wire logic                           ctrl_write_enable,
    output trace_monitor_pkg::trace_config_t    cfg
);
    import trace_monitor_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.range_lower_en   <= 1'b0;
            cfg.range_upper_en   <= 1'b0;
            cfg.range_lower      <= '0;
            cfg.range_upper      <= '1;
            cfg.trigger_start_en <= 1'b0;
            cfg.trigger_end_en   <= 1'b0;
            cfg.trigger_start    <= '0;
            cfg.trigger_end      <= '1;
            // halting on a full buffer is on out of reset
            cfg.halt_on_full_en  <= 1'b1;
            cfg.forced_halt      <= 1'b0;
            cfg.wfi_stop_clear   <= 1'b0;
        end else begin
            cfg.wfi_stop_clear <= 1'b0;
            if (ctrl_write_enable) begin
                case (ctrl_addr)
                    RANGE_LOWER_EN:   cfg.range_lower_en   <= ctrl_wdata[0];
                    RANGE_UPPER_EN:   cfg.range_upper_en   <= ctrl_wdata[0];
                    RANGE_LOWER:      cfg.range_lower      <= ctrl_wdata;
                    RANGE_UPPER:      cfg.range_upper      <= ctrl_wdata;
                    TRIGGER_START_EN: cfg.trigger_start_en <= ctrl_wdata[0];
                    TRIGGER_END_EN:   cfg.trigger_end_en   <= ctrl_wdata[0];
                    TRIGGER_START:    cfg.trigger_start    <= ctrl_wdata;
                    TRIGGER_END:      cfg.trigger_end      <= ctrl_wdata;
                    // re-arms the wfi stop, data is don't care
                    WFI_STOP:         cfg.wfi_stop_clear   <= 1'b1;
                    HALT_ON_FULL_EN:  cfg.halt_on_full_en  <= ctrl_wdata[0];
                    FORCED_HALT:      cfg.forced_halt      <= ctrl_wdata[0];
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: source/trace_monitor_pkg.sv
/*
 * trace monitor types
 * control address enum, trace record and configuration structs
 */
`default_nettype none

`include "trace_monitor_config.svh"

package trace_monitor_pkg;

    // control port register map, unlisted codes are ignored
    typedef enum logic [3:0] {
        RANGE_LOWER_EN   = 4'd0,
        RANGE_UPPER_EN   = 4'd1,
        RANGE_LOWER      = 4'd2,
        RANGE_UPPER      = 4'd3,
        TRIGGER_START_EN = 4'd4,
        TRIGGER_END_EN   = 4'd5,
        TRIGGER_START    = 4'd6,
        TRIGGER_END      = 4'd7,
        WFI_STOP         = 4'd8,
        HALT_ON_FULL_EN  = 4'd9,
        FORCED_HALT      = 4'd10
    } ctrl_addr_e;

    // 96 data bits plus the last flag
    typedef struct packed {
        logic [`TRACE_XLEN-1:0]        pc;
        logic [`TRACE_INSTR_WIDTH-1:0] instr;
        logic [`TRACE_DELTA_WIDTH-1:0] delta;
        logic                          last;
    } trace_record_t;

    typedef struct packed {
        logic                   range_lower_en;
        logic                   range_upper_en;
        logic [`TRACE_XLEN-1:0] range_lower;
        logic [`TRACE_XLEN-1:0] range_upper;
        logic                   trigger_start_en;
        logic                   trigger_end_en;
        logic [`TRACE_XLEN-1:0] trigger_start;
        logic [`TRACE_XLEN-1:0] trigger_end;
        logic                   halt_on_full_en;
        logic                   forced_halt;
        // single cycle pulse
        logic                   wfi_stop_clear;
    } trace_config_t;

endpackage

`default_nettype wire

// File: source/trace_monitor_top.sv
/*
 * trace monitor top level
 * control registers, capture, buffer, stream output and cpu halt
 */
`timescale 1ns/1ps
`default_nettype none

`include "trace_monitor_config.svh"

module trace_monitor_top (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic [`TRACE_XLEN-1:0]        pc,
    input  wire logic [`TRACE_INSTR_WIDTH-1:0] instr,
    input  wire logic                          en,
    input  wire trace_monitor_pkg::ctrl_addr_e ctrl_addr,
    input  wire logic [`TRACE_XLEN-1:0]        ctrl_wdata,
    input  wire logic                          ctrl_write_enable,
    output logic                               tvalid,
    input  wire logic                          tready,
    output logic [`TRACE_DATA_WIDTH-1:0]       tdata,
    output logic                               tlast,
    output logic                               halt_cpu
);
    import trace_monitor_pkg::*;

    trace_config_t cfg;
    logic          buf_full;

    trace_record_if cap_if ();
    trace_record_if buf_if ();

    trace_control_regs trace_control_regs_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .ctrl_addr         (ctrl_addr),
        .ctrl_wdata        (ctrl_wdata),
        .ctrl_write_enable (ctrl_write_enable),
        .cfg               (cfg)
    );

    trace_capture trace_capture_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .pc    (pc),
        .instr (instr),
        .en    (en),
        .cfg   (cfg),
        .out   (cap_if.source)
    );

    trace_buffer trace_buffer_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (cap_if.sink),
        .out   (buf_if.source),
        .full  (buf_full)
    );

    trace_stream_out trace_stream_out_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .in     (buf_if.sink),
        .tvalid (tvalid),
        .tready (tready),
        .tdata  (tdata),
        .tlast  (tlast)
    );

    // stall the core while the buffer cannot take more records
    assign halt_cpu = (cfg.halt_on_full_en && buf_full) || cfg.forced_halt;

endmodule

`default_nettype wire

// File: source/trace_record_if.sv
/*
 * valid/ready link carrying one trace record per transfer
 */
`timescale 1ns/1ps
`default_nettype none

interface trace_record_if;
    import trace_monitor_pkg::*;

    logic          valid;
    logic          ready;
    trace_record_t record;

    // valid and record stay stable until valid && ready at a clock edge
    modport source (
        output valid,
        output record,
        input  ready
    );

    modport sink (
        input  valid,
        input  record,
        output ready
    );

endinterface

`default_nettype wire

// File: source/trace_stream_out.sv
/*
 * output stage: one record register driving the tvalid/tready stream
 */
`timescale 1ns/1ps
`default_nettype none

`include "trace_monitor_config.svh"

module trace_stream_out (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    trace_record_if.sink                     in,
    output logic                             tvalid,
    input  wire logic                        tready,
    output logic [`TRACE_DATA_WIDTH-1:0]     tdata,
    output logic                             tlast
);
    logic [`TRACE_DATA_WIDTH-1:0] data_q;
    logic                         last_q;
    logic                         take;

    // refill in the same cycle the held record leaves
    assign in.ready = !tvalid || tready;
    assign take     = in.valid && in.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tvalid <= 1'b0;
        end else if (in.ready) begin
            tvalid <= in.valid;
        end
    end

    // instr in the top bits, delta in the low bits
    always_ff @(posedge clk) begin
        if (take) begin
            data_q <= {in.record.instr, in.record.pc, in.record.delta};
            last_q <= in.record.last;
        end
    end

    assign tdata = data_q;
    assign tlast = last_q;

endmodule

`default_nettype wire

// File: verification/trace_monitor_tb.sv
/*
 * testbench for the trace monitor
 * clock, random pc runs, reference model of the trace records,
 * record comparison and watchdog
 */
`timescale 1ns/1ps
`default_nettype none

`include "trace_monitor_config.svh"

module trace_monitor_tb;
    import trace_monitor_pkg::*;

    // rough cycle budget of all phases, halt stalls included
    localparam int  STIM_CYCLES = 4000;
    localparam real WATCHDOG_NS = STIM_CYCLES * 4.0 + 2000.0;
    localparam logic [31:0] WFI = `TRACE_WFI_INSTR;

    logic        clk;
    logic        rst_n;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        en;
    ctrl_addr_e  ctrl_addr;
    logic [31:0] ctrl_wdata;
    logic        ctrl_write_enable;
    logic        tvalid;
    logic        tready;
    logic [95:0] tdata;
    logic        tlast;
    logic        halt_cpu;

    // per cycle log of what the core presented
    logic [31:0]   log_pc[$];
    logic [31:0]   log_instr[$];
    logic          log_en[$];
    trace_config_t log_cfg[$];
    trace_config_t shadow_cfg;

    trace_record_t exp_q[$];
    bit            exp_delta_known[$];
    trace_record_t act_q[$];

    logic [31:0] rng_state;
    logic [31:0] last_pc;
    bit          tready_random;
    bit          saw_halt;
    int          errors;
    int          checks;
    int          checked;

    trace_monitor_top trace_monitor_top_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .pc                (pc),
        .instr             (instr),
        .en                (en),
        .ctrl_addr         (ctrl_addr),
        .ctrl_wdata        (ctrl_wdata),
        .ctrl_write_enable (ctrl_write_enable),
        .tvalid            (tvalid),
        .tready            (tready),
        .tdata             (tdata),
        .tlast             (tlast),
        .halt_cpu          (halt_cpu)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // expected records of the whole log, one per kept run end or wfi stop
    function automatic void compute_expected();
        bit            start_hit;
        bit            end_hit;
        int            wcnt;
        int            prev;
        bit            is_wfi;
        bit            fire;
        bit            run_end;
        bit            in_range;
        bit            in_window;
        trace_config_t c;
        trace_record_t r;
        start_hit = 0;
        end_hit = 0;
        wcnt = 0;
        prev = -1;
        exp_q.delete();
        exp_delta_known.delete();
        for (int i = 0; i < log_pc.size() - 1; i++) begin
            c = log_cfg[i];
            if (c.trigger_start_en && log_pc[i] == c.trigger_start) begin
                start_hit = 1;
                end_hit = 0;
            end
            if (c.trigger_end_en && log_pc[i] == c.trigger_end) begin
                end_hit = 1;
                start_hit = 0;
            end
            is_wfi = (log_instr[i] == WFI);
            fire = 0;
            if (!is_wfi) begin
                wcnt = 0;
            end else begin
                fire = log_en[i] && (wcnt == `TRACE_WFI_THRESHOLD - 1);
                if (log_en[i] && wcnt < `TRACE_WFI_THRESHOLD) begin
                    wcnt++;
                end
            end
            run_end = (log_pc[i] != log_pc[i+1]) && (log_pc[i] != 0) && !is_wfi;
            in_range = (!c.range_lower_en || log_pc[i] >= c.range_lower) &&
                       (!c.range_upper_en || log_pc[i] <= c.range_upper);
            in_window = (start_hit || !c.trigger_start_en) && (!end_hit || !c.trigger_end_en);
            if ((run_end || fire) && log_en[i] && in_range && in_window) begin
                r.pc    = log_pc[i];
                r.instr = log_instr[i];
                r.delta = (prev < 0) ? 32'd0 : 32'(i - prev);
                r.last  = fire;
                exp_q.push_back(r);
                exp_delta_known.push_back(prev >= 0);
                prev = i;
            end
        end
    endfunction

    // one clock cycle; pc and instr stay frozen while halt_cpu is high
    task automatic next_cycle(input logic [31:0] pc_v, input logic [31:0] instr_v,
                              output bit advanced);
        @(posedge clk);
        #1;
        tready = tready_random ? (next_rand() % 8 == 0) : 1'b1;
        if (halt_cpu) begin
            saw_halt = 1;
            advanced = 0;
        end else begin
            pc = pc_v;
            instr = instr_v;
            advanced = 1;
        end
        log_pc.push_back(pc);
        log_instr.push_back(instr);
        log_en.push_back(en);
        log_cfg.push_back(shadow_cfg);
    endtask

    task automatic drive_run(input logic [31:0] pc_v, input logic [31:0] instr_v,
                             input int len);
        int done;
        bit adv;
        done = 0;
        while (done < len) begin
            next_cycle(pc_v, instr_v, adv);
            if (adv) begin
                done++;
            end
        end
    endtask

    task automatic idle(input int n);
        drive_run(32'h0, 32'h0, n);
    endtask

    task automatic wait_cycles(input int n);
        bit adv;
        for (int i = 0; i < n; i++) begin
            next_cycle(32'h0, 32'h0, adv);
        end
    endtask

    task automatic write_ctrl(input ctrl_addr_e addr, input logic [31:0] data);
        bit adv;
        ctrl_addr = addr;
        ctrl_wdata = data;
        ctrl_write_enable = 1'b1;
        case (addr)
            RANGE_LOWER_EN:   shadow_cfg.range_lower_en = data[0];
            RANGE_UPPER_EN:   shadow_cfg.range_upper_en = data[0];
            RANGE_LOWER:      shadow_cfg.range_lower = data;
            RANGE_UPPER:      shadow_cfg.range_upper = data;
            TRIGGER_START_EN: shadow_cfg.trigger_start_en = data[0];
            TRIGGER_END_EN:   shadow_cfg.trigger_end_en = data[0];
            TRIGGER_START:    shadow_cfg.trigger_start = data;
            TRIGGER_END:      shadow_cfg.trigger_end = data;
            HALT_ON_FULL_EN:  shadow_cfg.halt_on_full_en = data[0];
            FORCED_HALT:      shadow_cfg.forced_halt = data[0];
            default: begin
            end
        endcase
        next_cycle(32'h0, 32'h0, adv);
        ctrl_write_enable = 1'b0;
        // plain clock cycles, a forced halt keeps the core frozen here
        wait_cycles(2);
    endtask

    task automatic random_runs(input int n, input int min_len);
        logic [31:0] pc_v;
        logic [31:0] instr_v;
        int          len;
        for (int i = 0; i < n; i++) begin
            pc_v = 32'h1000 + ((next_rand() % 64) << 2);
            if (pc_v == last_pc) begin
                pc_v = pc_v + 4;
            end
            instr_v = next_rand();
            if (instr_v == WFI) begin
                instr_v = instr_v ^ 32'h1;
            end
            len = min_len + int'(next_rand() % (7 - min_len));
            drive_run(pc_v, instr_v, len);
            last_pc = pc_v;
        end
    endtask

    task automatic check_records(input string phase);
        int waited;
        int n;
        idle(6);
        compute_expected();
        waited = 0;
        while (act_q.size() < exp_q.size() && waited < 400) begin
            idle(1);
            waited++;
        end
        checks++;
        assert (act_q.size() >= exp_q.size()) else begin
            errors++;
            $display("%s: timed out waiting for records, %0d of %0d arrived",
                     phase, act_q.size(), exp_q.size());
        end
        idle(8);
        checks++;
        assert (act_q.size() == exp_q.size()) else begin
            errors++;
            $display("%s: got %0d records where %0d were expected",
                     phase, act_q.size(), exp_q.size());
        end
        n = (act_q.size() < exp_q.size()) ? act_q.size() : exp_q.size();
        for (int i = checked; i < n; i++) begin
            checks++;
            assert (act_q[i].pc == exp_q[i].pc) else begin
                errors++;
                $display("Error: %s record %0d tdata.pc 0x%h expected 0x%h",
                         phase, i, act_q[i].pc, exp_q[i].pc);
            end
            assert (act_q[i].instr == exp_q[i].instr) else begin
                errors++;
                $display("Error: %s record %0d tdata.instr 0x%h expected 0x%h",
                         phase, i, act_q[i].instr, exp_q[i].instr);
            end
            assert (!exp_delta_known[i] || act_q[i].delta == exp_q[i].delta) else begin
                errors++;
                $display("Error: %s record %0d tdata.delta 0x%h expected 0x%h",
                         phase, i, act_q[i].delta, exp_q[i].delta);
            end
            assert (act_q[i].last == exp_q[i].last) else begin
                errors++;
                $display("Error: %s record %0d tlast 0x%h expected 0x%h",
                         phase, i, act_q[i].last, exp_q[i].last);
            end
        end
        checked = act_q.size();
    endtask

    // the transfer happens at the next rising edge
    always @(negedge clk) begin
        trace_record_t r;
        if (rst_n && tvalid && tready) begin
            r.instr = tdata[95:64];
            r.pc    = tdata[63:32];
            r.delta = tdata[31:0];
            r.last  = tlast;
            act_q.push_back(r);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all phases finished");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int cnt0;
        pc = '0;
        instr = '0;
        en = 1'b0;
        ctrl_addr = RANGE_LOWER_EN;
        ctrl_wdata = '0;
        ctrl_write_enable = 1'b0;
        tready = 1'b0;
        rst_n = 1'b0;
        rng_state = 32'd90585;
        last_pc = '0;
        tready_random = 0;
        saw_halt = 0;
        errors = 0;
        checks = 0;
        checked = 0;
        shadow_cfg = '0;
        shadow_cfg.range_upper = '1;
        shadow_cfg.trigger_end = '1;
        shadow_cfg.halt_on_full_en = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        en = 1'b1;
        idle(4);

        random_runs(30, 1);
        check_records("plain");

        write_ctrl(RANGE_LOWER, 32'h1040);
        write_ctrl(RANGE_UPPER, 32'h10bf);
        write_ctrl(RANGE_LOWER_EN, 32'h1);
        write_ctrl(RANGE_UPPER_EN, 32'h1);
        random_runs(40, 1);
        check_records("range");
        write_ctrl(RANGE_LOWER_EN, 32'h0);
        write_ctrl(RANGE_UPPER_EN, 32'h0);

        write_ctrl(TRIGGER_START, 32'h2000);
        write_ctrl(TRIGGER_END, 32'h2100);
        write_ctrl(TRIGGER_START_EN, 32'h1);
        write_ctrl(TRIGGER_END_EN, 32'h1);
        random_runs(8, 1);
        drive_run(32'h2000, 32'h00000013, 3);
        random_runs(8, 1);
        drive_run(32'h2100, 32'h00000013, 3);
        random_runs(8, 1);
        check_records("trigger");
        write_ctrl(TRIGGER_START_EN, 32'h0);
        write_ctrl(TRIGGER_END_EN, 32'h0);

        random_runs(5, 1);
        drive_run(32'h3000, WFI, 24);
        random_runs(5, 1);
        check_records("wfi");

        tready_random = 1;
        random_runs(60, 2);
        tready_random = 0;
        check_records("back-pressure");
        checks++;
        assert (saw_halt) else begin
            errors++;
            $display("halt_cpu never rose while the stream was stalled");
        end
        write_ctrl(FORCED_HALT, 32'h1);
        wait_cycles(2);
        checks++;
        assert (halt_cpu === 1'b1) else begin
            errors++;
            $display("Error: halt_cpu 0x%h expected 0x1 with forced halt set", halt_cpu);
        end
        write_ctrl(FORCED_HALT, 32'h0);
        wait_cycles(2);
        checks++;
        assert (halt_cpu === 1'b0) else begin
            errors++;
            $display("Error: halt_cpu 0x%h expected 0x0 after forced halt cleared", halt_cpu);
        end

        en = 1'b0;
        idle(4);
        random_runs(20, 1);
        idle(4);
        en = 1'b1;
        check_records("enable");
        cnt0 = act_q.size();
        drive_run(32'h4000, 32'h00000013, 40);
        checks++;
        assert (act_q.size() == cnt0) else begin
            errors++;
            $display("a record appeared while the pc was held unchanged");
        end
        check_records("unchanged run");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
